// ==== bench/tbTrellis.sv ====
// directed testbench for the trellis front end, compiled from flist.f with tbTrellis as top
`timescale 1ns/1ns
`include "trellis_config.svh"

module tbTrellis;
   import trellisDspPkg::*;
   import trellisHostPkg::*;

   // enables used by all tests together, the watchdog allows 8 clocks each
   localparam int enableCount    = 20 + 12 + 5 + 1;
   localparam int watchdogClocks = enableCount * 8 + 120;
   localparam logic [`ADDR_BITS-1:0] decayAddr = {`TRELLIS_SPACE, `TRELLIS_DECAY};

   logic                   clk, rst, sym2xEn, wr;
   sampleWord              iIn, qIn, mfmI, mfmQ, mfpI, mfpQ;
   logic [`PHERR_BITS-1:0] phaseError;
   logic [1:0]             index;
   hostAddr                addr;
   hostData                din, dout;
   logic [7:0]             decayFactor;
   dacSel                  dacSelect [0:2];
   dacWord                 dacData [0:2];
   logic [2:0]             dacSync;
   logic                   ternarySymEnOut, ternarySym2xEnOut;
   rotArray                rotReal, rotImag;

   int    seed = 55988;
   int    checks;
   int    errors;
   int    testErrs;
   string testName;

   trellisFrontEnd i_trellisFrontEnd (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ------------------------------
   // reference model
   // ------------------------------
   // top ROT_BITS of the sample
   function automatic rotWord quantCut(input sampleWord s);
      sampleWord t;
      t = s >>> (`SAMPLE_BITS - `ROT_BITS);
      return rotWord'(t);
   endfunction

   // halved, so one more bit is dropped
   function automatic rotWord quantHalf(input sampleWord s);
      sampleWord t;
      t = s >>> (`SAMPLE_BITS - `ROT_BITS + 1);
      return rotWord'(t);
   endfunction

   function automatic rotWord rotRe(input rotWord re, input rotWord im, input int r);
      case (r)
         0: return re;
         1: return im;
         2: return -re;
         default: return -im;
      endcase
   endfunction

   function automatic rotWord rotIm(input rotWord re, input rotWord im, input int r);
      case (r)
         0: return im;
         1: return -re;
         2: return -im;
         default: return re;
      endcase
   endfunction

   // undefined select codes show the phase error
   function automatic dacWord dacExpect(input logic [3:0] sel);
      case (sel)
         `DAC_TRELLIS_I:     return iIn;
         `DAC_TRELLIS_Q:     return qIn;
         `DAC_TRELLIS_INDEX: return dacWord'(index) << 12;
         default:            return dacWord'(phaseError) << 8;
      endcase
   endfunction

   // ------------------------------
   // check helpers
   // ------------------------------
   task automatic checkVal(input string what, input logic [31:0] expVal,
                           input logic [31:0] actVal);
      checks++;
      assert (actVal === expVal)
      else begin
         $display("Error %s %s: expected %h, actual %h", testName, what, expVal, actVal);
         errors++;
         testErrs++;
      end
   endtask

   task automatic startTest(input string name);
      testName = name;
      testErrs = 0;
   endtask

   task automatic endTest();
      $display("%s done, %0d errors", testName, testErrs);
   endtask

   task automatic checkFilter(input filterIdx f, input rotWord re, input rotWord im);
      for (int r = 0; r < 4; r++) begin
         checkVal($sformatf("%s rot%0d re", f.name(), r), rotRe(re, im, r), rotReal[f][r]);
         checkVal($sformatf("%s rot%0d im", f.name(), r), rotIm(re, im, r), rotImag[f][r]);
      end
   endtask

   // called on a falling edge, returns one clock later with the enable low
   task automatic pulseEnable();
      sym2xEn = 1'b1;
      @(negedge clk);
      sym2xEn = 1'b0;
   endtask

   task automatic hostWrite(input logic [`ADDR_BITS-1:0] a, input hostData d);
      @(negedge clk);
      wr       = 1'b1;
      addr.raw = a;
      din      = d;
      @(negedge clk);
      wr = 1'b0;
   endtask

   task automatic readCheck(input logic [`ADDR_BITS-1:0] a, input hostData expVal);
      @(negedge clk);
      addr.raw = a;
      @(negedge clk);
      checkVal($sformatf("read %h", a), expVal, dout);
   endtask

   // ------------------------------
   // tests
   // ------------------------------
   task automatic testAfterReset();
      startTest("afterReset");
      checkVal("dacSync", 0, dacSync);
      checkVal("2x enable", 0, ternarySym2xEnOut);
      for (int f = 0; f < 3; f++) begin
         for (int r = 0; r < 4; r++) begin
            checkVal($sformatf("rotReal %0d %0d", f, r), 0, rotReal[f][r]);
            checkVal($sformatf("rotImag %0d %0d", f, r), 0, rotImag[f][r]);
         end
      end
      readCheck(decayAddr, `DECAY_RESET);
      endTest();
   endtask

   task automatic testDecay();
      startTest("decayRegister");
      hostWrite(decayAddr, 32'hFFFF_FF5A);
      readCheck(decayAddr, 32'h5A);
      checkVal("decayFactor", 8'h5A, decayFactor);
      // wrong offset, then wrong space
      hostWrite({`TRELLIS_SPACE, 4'h3}, 32'h11);
      hostWrite({8'h41, `TRELLIS_DECAY}, 32'h22);
      checkVal("decayFactor kept", 8'h5A, decayFactor);
      readCheck({`TRELLIS_SPACE, 4'h3}, 0);
      readCheck({8'h41, `TRELLIS_DECAY}, 0);
      readCheck(decayAddr, 32'h5A);
      endTest();
   endtask

   task automatic testMinusPlus();
      startTest("minusPlus");
      repeat (20) begin
         repeat (2) @(negedge clk);
         mfmI = $random(seed);
         mfmQ = $random(seed);
         mfpI = $random(seed);
         mfpQ = $random(seed);
         pulseEnable();
         checkFilter(filtMinus, quantCut(mfmI), quantCut(mfmQ));
         checkFilter(filtPlus, quantCut(mfpI), quantCut(mfpQ));
      end
      endTest();
   endtask

   task automatic testZeroPath();
      sampleWord pendI [$];
      sampleWord pendQ [$];
      sampleWord oldI;
      sampleWord oldQ;
      startTest("zeroPath");
      // earlier enables only shifted zeros in
      repeat (`ZERO_DELAY) begin
         pendI.push_back('0);
         pendQ.push_back('0);
      end
      repeat (12) begin
         repeat (2) @(negedge clk);
         iIn = $random(seed);
         qIn = $random(seed);
         pulseEnable();
         oldI = pendI.pop_front();
         oldQ = pendQ.pop_front();
         pendI.push_back(iIn);
         pendQ.push_back(qIn);
         checkFilter(filtZero, quantHalf(oldI), quantHalf(oldQ));
      end
      endTest();
   endtask

   task automatic testDac();
      dacSel codes [5];
      startTest("dacMux");
      codes = '{dacI, dacQ, dacPhErr, dacIndex, dacSel'(4'hB)};
      @(negedge clk);
      // every code reaches every channel over five rounds
      for (int k = 0; k < 5; k++) begin
         @(negedge clk);
         iIn        = $random(seed);
         qIn        = $random(seed);
         phaseError = $random(seed);
         index      = $random(seed);
         for (int ch = 0; ch < 3; ch++) begin
            dacSelect[ch] = codes[(k + ch) % 5];
         end
         pulseEnable();
         for (int ch = 0; ch < 3; ch++) begin
            checkVal($sformatf("dacData%0d sel %h", ch, dacSelect[ch]),
                     dacExpect(dacSelect[ch]), dacData[ch]);
         end
         checkVal("dacSync after enable", 3'b111, dacSync);
         @(negedge clk);
         checkVal("dacSync idle", 0, dacSync);
      end
      endTest();
   endtask

   task automatic testTwoX();
      startTest("twoXEnable");
      for (int c = -2; c <= 4; c++) begin
         @(negedge clk);
         sym2xEn = (c == 0);
         #1;
         checkVal($sformatf("1x enable clock %0d", c), (c == 0), ternarySymEnOut);
         checkVal($sformatf("2x enable clock %0d", c), (c == 0 || c == 1), ternarySym2xEnOut);
      end
      endTest();
   endtask

   // ------------------------------
   // watchdog and main sequence
   // ------------------------------
   initial begin
      repeat (watchdogClocks) @(posedge clk);
      $display("watchdog expired before the tests finished");
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      rst          = 1'b1;
      sym2xEn      = 1'b0;
      wr           = 1'b0;
      iIn          = '0;
      qIn          = '0;
      mfmI         = '0;
      mfmQ         = '0;
      mfpI         = '0;
      mfpQ         = '0;
      phaseError   = '0;
      index        = '0;
      addr.raw     = '0;
      din          = '0;
      dacSelect    = '{dacI, dacI, dacI};
      checks       = 0;
      errors       = 0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      testAfterReset();
      testDecay();
      testMinusPlus();
      testZeroPath();
      testDac();
      testTwoX();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+include
rtl/trellisDspPkg.sv
rtl/trellisHostPkg.sv
rtl/mfBus.sv
rtl/mfAlign.sv
rtl/rotationBank.sv
rtl/trellisMonitor.sv
rtl/trellisFrontEnd.sv
bench/tbTrellis.sv

// ==== include/trellis_config.svh ====
// widths, delays, host addresses and DAC select codes, included by packages and RTL
`ifndef TRELLIS_CONFIG_SVH
`define TRELLIS_CONFIG_SVH

// ------------------------------
// signal path
// ------------------------------
`define SAMPLE_BITS 18
`define ROT_BITS 10
`define ZERO_DELAY 4
`define PHERR_BITS 10

// ------------------------------
// host register space
// ------------------------------
`define DECAY_RESET 8'hFF
`define ADDR_BITS 12
`define DATA_BITS 32
`define SPACE_BITS 8
`define TRELLIS_SPACE 8'h40
`define TRELLIS_DECAY 4'h2

// DAC monitor select codes
`define DAC_TRELLIS_I 4'h0
`define DAC_TRELLIS_Q 4'h1
`define DAC_TRELLIS_PHERR 4'h2
`define DAC_TRELLIS_INDEX 4'h3

`endif

// ==== rtl/mfAlign.sv ====
// zero-path delay line and quantization of the three matched-filter outputs onto mfBus
`timescale 1ns/1ns
`include "trellis_config.svh"

module mfAlign (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    sym2xEn,
   input  trellisDspPkg::sampleWord iIn,
   input  trellisDspPkg::sampleWord qIn,
   input  trellisDspPkg::sampleWord mfmI,
   input  trellisDspPkg::sampleWord mfmQ,
   input  trellisDspPkg::sampleWord mfpI,
   input  trellisDspPkg::sampleWord mfpQ,
   mfBus.src                       bus
);
   import trellisDspPkg::*;

   // zero path delay taps, tap 0 is the newest
   sampleWord zDlyI [`ZERO_DELAY];
   sampleWord zDlyQ [`ZERO_DELAY];

   // top ROT_BITS of the sample
   function automatic rotWord cutWord(input sampleWord s);
      return s[`SAMPLE_BITS-1 -: `ROT_BITS];
   endfunction

   // divide by two with sign extension, then cut
   function automatic rotWord halfWord(input sampleWord s);
      return {s[`SAMPLE_BITS-1], s[`SAMPLE_BITS-1 -: `ROT_BITS-1]};
   endfunction

   // ------------------------------
   // zero path delay line
   // ------------------------------
   // lines the unfiltered samples up with the minus and plus filter latency
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `ZERO_DELAY; i++) begin
            zDlyI[i] <= '0;
            zDlyQ[i] <= '0;
         end
      end else if (sym2xEn) begin
         zDlyI[0] <= iIn;
         zDlyQ[0] <= qIn;
         for (int i = 1; i < `ZERO_DELAY; i++) begin
            zDlyI[i] <= zDlyI[i-1];
            zDlyQ[i] <= zDlyQ[i-1];
         end
      end
   end

   // ------------------------------
   // quantized words
   // ------------------------------
   assign bus.en  = sym2xEn;
   assign bus.zRe = halfWord(zDlyI[`ZERO_DELAY-1]);
   assign bus.zIm = halfWord(zDlyQ[`ZERO_DELAY-1]);
   assign bus.mRe = cutWord(mfmI);
   assign bus.mIm = cutWord(mfmQ);
   assign bus.pRe = cutWord(mfpI);
   assign bus.pIm = cutWord(mfpQ);

   // the 2x enable downstream needs two idle clocks after each pulse
   enSpacing: assert property (@(posedge clk) disable iff (rst)
      sym2xEn |=> !sym2xEn [*2]);

endmodule

// ==== rtl/mfBus.sv ====
// aligned and quantized filter words passed from mfAlign to rotationBank once per symbol
`timescale 1ns/1ns

interface mfBus;
   import trellisDspPkg::*;

   // symbol enable, one pulse per symbol
   logic   en;

   // zero path, already delayed and halved
   rotWord zRe;
   rotWord zIm;

   // minus and plus paths
   rotWord mRe;
   rotWord mIm;
   rotWord pRe;
   rotWord pIm;

   modport src (
      output en, zRe, zIm, mRe, mIm, pRe, pIm
   );

   modport dst (
      input en, zRe, zIm, mRe, mIm, pRe, pIm
   );

endinterface

// ==== rtl/rotationBank.sv ====
// four quarter-turn rotations of each filter word, held from one symbol enable to the next
`timescale 1ns/1ns
`include "trellis_config.svh"

module rotationBank (
   input  logic                  clk,
   input  logic                  rst,
   mfBus.dst                     bus,
   output trellisDspPkg::rotArray rotReal,
   output trellisDspPkg::rotArray rotImag
);
   import trellisDspPkg::*;

   // bus words regrouped by filter
   rotWord  inRe [3];
   rotWord  inIm [3];
   rotArray nextReal;
   rotArray nextImag;

   // two's complement, wraps at the most negative value
   function automatic rotWord negWord(input rotWord w);
      return rotWord'(-w);
   endfunction

   always_comb begin
      inRe[filtZero]  = bus.zRe;
      inIm[filtZero]  = bus.zIm;
      inRe[filtMinus] = bus.mRe;
      inIm[filtMinus] = bus.mIm;
      inRe[filtPlus]  = bus.pRe;
      inIm[filtPlus]  = bus.pIm;
   end

   // ------------------------------
   // rotations
   // ------------------------------
   // multiply by 1, -j, -1, +j
   always_comb begin
      for (int f = 0; f < 3; f++) begin
         nextReal[f][0] = inRe[f];
         nextImag[f][0] = inIm[f];
         nextReal[f][1] = inIm[f];
         nextImag[f][1] = negWord(inRe[f]);
         nextReal[f][2] = negWord(inRe[f]);
         nextImag[f][2] = negWord(inIm[f]);
         nextReal[f][3] = negWord(inIm[f]);
         nextImag[f][3] = inRe[f];
      end
   end

   // ------------------------------
   // output registers
   // ------------------------------
   // sampled once per symbol
   always_ff @(posedge clk) begin
      if (rst) begin
         rotReal <= '0;
         rotImag <= '0;
      end else if (bus.en) begin
         rotReal <= nextReal;
         rotImag <= nextImag;
      end
   end

   // half turn of the held word, checked right after each update
   for (genvar f = 0; f < 3; f++) begin : gHalfTurn
      halfTurn: assert property (@(posedge clk) disable iff (rst)
         bus.en |=> (rotReal[f][2] == negWord(rotReal[f][0])) &&
                    (rotImag[f][2] == negWord(rotImag[f][0])));
   end

endmodule

// ==== rtl/trellisDspPkg.sv ====
// signal path types shared by the aligner, the rotation bank and the top level
`include "trellis_config.svh"

package trellisDspPkg;

   // ------------------------------
   // sample and rotated words
   // ------------------------------

   // raw matched-filter output or input sample
   typedef logic signed [`SAMPLE_BITS-1:0] sampleWord;

   // quantized word, also used for each rotation
   typedef logic signed [`ROT_BITS-1:0] rotWord;

   // ------------------------------
   // rotation bank layout
   // ------------------------------

   // filter order matches the first index of rotArray
   typedef enum logic [1:0] {
      filtZero  = 2'd0,
      filtMinus = 2'd1,
      filtPlus  = 2'd2
   } filterIdx;

   // [filter][rotation], rotation 0 is the unrotated word
   typedef rotWord [0:2][0:3] rotArray;

endpackage

// ==== rtl/trellisFrontEnd.sv ====
// symbol-rate front end of the SOQPSK trellis demodulator, top level with plain ports
`timescale 1ns/1ns
`include "trellis_config.svh"

module trellisFrontEnd (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     sym2xEn,
   // zero path samples and external matched filters
   input  trellisDspPkg::sampleWord iIn,
   input  trellisDspPkg::sampleWord qIn,
   input  trellisDspPkg::sampleWord mfmI,
   input  trellisDspPkg::sampleWord mfmQ,
   input  trellisDspPkg::sampleWord mfpI,
   input  trellisDspPkg::sampleWord mfpQ,
   // from the trellis decoder
   input  logic [`PHERR_BITS-1:0]   phaseError,
   input  logic [1:0]               index,
   // host bus
   input  logic                     wr,
   input  trellisHostPkg::hostAddr  addr,
   input  trellisHostPkg::hostData  din,
   output trellisHostPkg::hostData  dout,
   output logic [7:0]               decayFactor,
   // DAC monitor
   input  trellisHostPkg::dacSel    dacSelect [0:2],
   output trellisHostPkg::dacWord   dacData [0:2],
   output logic [2:0]               dacSync,
   // enables and rotated words for the decoder
   output logic                     ternarySymEnOut,
   output logic                     ternarySym2xEnOut,
   output trellisDspPkg::rotArray   rotReal,
   output trellisDspPkg::rotArray   rotImag
);

   // one sample per symbol, so the single-rate enable is sym2xEn itself
   assign ternarySymEnOut = sym2xEn;

   mfBus mfLink ();

   // ------------------------------
   // signal path
   // ------------------------------
   mfAlign i_mfAlign (
      .clk     (clk),
      .rst     (rst),
      .sym2xEn (sym2xEn),
      .iIn     (iIn),
      .qIn     (qIn),
      .mfmI    (mfmI),
      .mfmQ    (mfmQ),
      .mfpI    (mfpI),
      .mfpQ    (mfpQ),
      .bus     (mfLink)
   );

   rotationBank i_rotationBank (
      .clk     (clk),
      .rst     (rst),
      .bus     (mfLink),
      .rotReal (rotReal),
      .rotImag (rotImag)
   );

   // ------------------------------
   // host and monitor
   // ------------------------------
   trellisMonitor i_trellisMonitor (
      .clk               (clk),
      .rst               (rst),
      .sym2xEn           (sym2xEn),
      .wr                (wr),
      .iIn               (iIn),
      .qIn               (qIn),
      .phaseError        (phaseError),
      .index             (index),
      .addr              (addr),
      .din               (din),
      .dout              (dout),
      .decayFactor       (decayFactor),
      .dacSelect         (dacSelect),
      .dacData           (dacData),
      .dacSync           (dacSync),
      .ternarySym2xEnOut (ternarySym2xEnOut)
   );

endmodule

// ==== rtl/trellisHostPkg.sv ====
// host bus and DAC monitor types used by the monitor and the top level
`include "trellis_config.svh"

package trellisHostPkg;

   // ------------------------------
   // host address
   // ------------------------------

   // upper field selects the register space, lower field the register
   typedef struct packed {
      logic [`SPACE_BITS-1:0]            space;
      logic [`ADDR_BITS-`SPACE_BITS-1:0] offset;
   } hostAddrFields;

   // raw view for range compares, field view for register decode
   typedef union packed {
      logic [`ADDR_BITS-1:0] raw;
      hostAddrFields         field;
   } hostAddr;

   typedef logic [`DATA_BITS-1:0] hostData;

   // ------------------------------
   // DAC monitor
   // ------------------------------
   typedef enum logic [3:0] {
      dacI     = `DAC_TRELLIS_I,
      dacQ     = `DAC_TRELLIS_Q,
      dacPhErr = `DAC_TRELLIS_PHERR,
      dacIndex = `DAC_TRELLIS_INDEX
   } dacSel;

   typedef logic signed [`SAMPLE_BITS-1:0] dacWord;

endpackage

// ==== rtl/trellisMonitor.sv ====
// decay factor register with host readback, 2x symbol enable and three-channel DAC monitor
`timescale 1ns/1ns
`include "trellis_config.svh"

module trellisMonitor (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     sym2xEn,
   input  logic                     wr,
   input  trellisDspPkg::sampleWord iIn,
   input  trellisDspPkg::sampleWord qIn,
   input  logic [`PHERR_BITS-1:0]   phaseError,
   input  logic [1:0]               index,
   input  trellisHostPkg::hostAddr  addr,
   input  trellisHostPkg::hostData  din,
   output trellisHostPkg::hostData  dout,
   output logic [7:0]               decayFactor,
   input  trellisHostPkg::dacSel    dacSelect [0:2],
   output trellisHostPkg::dacWord   dacData [0:2],
   output logic [2:0]               dacSync,
   output logic                     ternarySym2xEnOut
);
   import trellisHostPkg::*;

   localparam int offsetBits = `ADDR_BITS - `SPACE_BITS;
   localparam logic [`ADDR_BITS-1:0] spaceBase = {`TRELLIS_SPACE, {offsetBits{1'b0}}};
   localparam logic [`ADDR_BITS-1:0] spaceTop  = {`TRELLIS_SPACE, {offsetBits{1'b1}}};

   logic inSpace;
   logic decayHit;
   logic sym2xEnDly;

   // ------------------------------
   // host registers
   // ------------------------------
   // space check on the raw word, register pick on the offset field
   assign inSpace  = (addr.raw >= spaceBase) && (addr.raw <= spaceTop);
   assign decayHit = inSpace && (addr.field.offset == `TRELLIS_DECAY);

   always_ff @(posedge clk) begin
      if (rst) begin
         decayFactor <= `DECAY_RESET;
      end else if (wr && decayHit) begin
         decayFactor <= din[7:0];
      end
   end

   // unmapped addresses read as zero
   always_comb begin
      if (decayHit) begin
         dout = hostData'(decayFactor);
      end else begin
         dout = '0;
      end
   end

   // ------------------------------
   // 2x enable
   // ------------------------------
   // stretches each symbol enable over two clocks for the line decoder
   always_ff @(posedge clk) begin
      if (rst) begin
         sym2xEnDly <= 1'b0;
      end else begin
         sym2xEnDly <= sym2xEn;
      end
   end

   assign ternarySym2xEnOut = sym2xEn | sym2xEnDly;

   // ------------------------------
   // DAC mux
   // ------------------------------
   // same selection rule on every channel
   function automatic dacWord dacMux(input dacSel sel);
      dacWord result;
      case (sel)
         dacI:     result = iIn;
         dacQ:     result = qIn;
         dacIndex: result = dacWord'({index, 12'b0});
         // phase error also covers undefined codes
         default:  result = {phaseError, {(`SAMPLE_BITS-`PHERR_BITS){1'b0}}};
      endcase
      return result;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         dacSync <= '0;
         for (int ch = 0; ch < 3; ch++) begin
            dacData[ch] <= '0;
         end
      end else begin
         for (int ch = 0; ch < 3; ch++) begin
            dacData[ch] <= dacMux(dacSelect[ch]);
            dacSync[ch] <= sym2xEn;
         end
      end
   end

   // DAC sync markers must trace back to a symbol enable
   syncFromEn: assert property (@(posedge clk) disable iff (rst)
      (|dacSync) |-> $past(sym2xEn));

endmodule
